// ==== src/seq_pkg.sv ====
// ---------------------------------------------------------------------
// vector sequencer shared definitions
// table geometry, instruction field widths, slot states,
// functional unit codes and operand select encodings
// ---------------------------------------------------------------------
package seq_pkg;

    // instruction status table geometry
    localparam int NUM_SLOTS = 8;
    localparam int SLOT_W    = 3;
    localparam int COUNT_W   = 4;

    // instruction field widths
    localparam int REG_W   = 5;
    localparam int OP_W    = 4;
    localparam int SEL_W   = 2;
    localparam int VTYPE_W = 2;
    localparam int DATA_W  = 128;

    // payload per slot, laid out as
    // {dest, op, vsew, lmul, sel_a, sel_b, src_a, src_b, imm}
    localparam int ENTRY_W = OP_W + 2 * VTYPE_W + 2 * SEL_W + 4 * REG_W;

    // stage of a table entry
    typedef enum logic [2:0] {
        ST_EMPTY  = 3'd0,
        ST_ISSUED = 3'd1,
        ST_READ   = 3'd2,
        ST_EXEC   = 3'd3,
        ST_WB     = 3'd4
    } entry_state_e;

    // target functional unit
    typedef enum logic [1:0] {
        FU_NONE = 2'd0,
        FU_ALU  = 2'd1,
        FU_MUL  = 2'd2
    } fu_e;

    // operand source, only the two vreg codes read the register file
    typedef enum logic [1:0] {
        SEL_VREG     = 2'd0,
        SEL_VREG_ALT = 2'd1,
        SEL_SCALAR   = 2'd2,
        SEL_IMM      = 2'd3
    } sel_op_e;

endpackage

// ==== src/instr_status_table.sv ====
// ---------------------------------------------------------------------
// instruction status table
// eight age-ordered slots with the oldest at slot 0
// append on issue, issued to read promotion, dispatch and done
// marking, shift-down removal of the retiring entry
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module instr_status_table (
    input  logic                        clk,
    input  logic                        nrst,
    input  logic                        instr_valid,
    input  seq_pkg::fu_e                instr_unit,
    input  logic [seq_pkg::OP_W-1:0]    instr_op,
    input  logic [seq_pkg::VTYPE_W-1:0] instr_vsew,
    input  logic [seq_pkg::VTYPE_W-1:0] instr_lmul,
    input  logic [seq_pkg::SEL_W-1:0]   instr_sel_a,
    input  logic [seq_pkg::SEL_W-1:0]   instr_sel_b,
    input  logic [seq_pkg::REG_W-1:0]   instr_src_a,
    input  logic [seq_pkg::REG_W-1:0]   instr_src_b,
    input  logic [seq_pkg::REG_W-1:0]   instr_dest,
    input  logic [seq_pkg::REG_W-1:0]   instr_imm,
    input  logic                        alu_fire,
    input  logic                        mul_fire,
    input  logic                        done_alu,
    input  logic                        done_mul,
    input  logic                        retire,
    output logic                        instr_ready,
    output logic                        read_valid,
    output seq_pkg::fu_e                read_unit,
    output logic [seq_pkg::SLOT_W-1:0]  read_index,
    output logic [seq_pkg::OP_W-1:0]    read_op,
    output logic [seq_pkg::VTYPE_W-1:0] read_vsew,
    output logic [seq_pkg::VTYPE_W-1:0] read_lmul,
    output logic [seq_pkg::SEL_W-1:0]   read_sel_a,
    output logic [seq_pkg::SEL_W-1:0]   read_sel_b,
    output logic [seq_pkg::REG_W-1:0]   read_src_a,
    output logic [seq_pkg::REG_W-1:0]   read_src_b,
    output logic [seq_pkg::REG_W-1:0]   read_imm,
    output seq_pkg::entry_state_e       slot_state [seq_pkg::NUM_SLOTS],
    output logic [seq_pkg::REG_W-1:0]   slot_dest [seq_pkg::NUM_SLOTS],
    output logic                        wb_valid,
    output seq_pkg::fu_e                wb_unit,
    output logic [seq_pkg::REG_W-1:0]   wb_dest
);
    import seq_pkg::*;

    logic [COUNT_W-1:0]   count;
    fu_e                  unit_q [NUM_SLOTS];
    logic [ENTRY_W-1:0]   entry_q [NUM_SLOTS];
    entry_state_e         state_nxt [NUM_SLOTS];
    logic [SLOT_W-1:0]    iss_index;
    logic [SLOT_W-1:0]    wb_index;
    logic [SLOT_W-1:0]    app_index;
    logic                 accept;
    logic [NUM_SLOTS-1:0] exec_alu;
    logic [NUM_SLOTS-1:0] exec_mul;

    assign instr_ready = (count < COUNT_W'(NUM_SLOTS));
    assign accept      = instr_valid && instr_ready;
    // new entry lands above whatever survives this edge's retire
    assign app_index   = SLOT_W'(count - COUNT_W'(retire));

    // oldest read, issued and finished entries
    always_comb begin
        read_valid = 1'b0;
        read_index = '0;
        iss_index  = '0;
        wb_valid   = 1'b0;
        wb_index   = '0;
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            slot_dest[i] = entry_q[i][ENTRY_W-1 -: REG_W];
            exec_alu[i]  = (slot_state[i] == ST_EXEC) && (unit_q[i] == FU_ALU);
            exec_mul[i]  = (slot_state[i] == ST_EXEC) && (unit_q[i] == FU_MUL);
            if (slot_state[i] == ST_READ) begin
                read_valid = 1'b1;
                read_index = SLOT_W'(i);
            end
            if (slot_state[i] == ST_ISSUED) begin
                iss_index = SLOT_W'(i);
            end
            if (slot_state[i] == ST_WB) begin
                wb_valid = 1'b1;
                wb_index = SLOT_W'(i);
            end
        end
    end

    assign read_unit = unit_q[read_index];
    assign {read_op, read_vsew, read_lmul, read_sel_a, read_sel_b,
            read_src_a, read_src_b, read_imm} = entry_q[read_index][ENTRY_W-REG_W-1:0];
    assign wb_unit   = unit_q[wb_index];
    assign wb_dest   = slot_dest[wb_index];

    // per-slot stage advance before any shift
    always_comb begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            state_nxt[i] = slot_state[i];
            case (slot_state[i])
                ST_ISSUED: begin
                    // read stage holds one entry at a time
                    if (!read_valid && iss_index == SLOT_W'(i)) begin
                        state_nxt[i] = ST_READ;
                    end
                end
                ST_READ: begin
                    if (alu_fire || mul_fire) begin
                        state_nxt[i] = ST_EXEC;
                    end
                end
                ST_EXEC: begin
                    if ((done_alu && unit_q[i] == FU_ALU) ||
                        (done_mul && unit_q[i] == FU_MUL)) begin
                        state_nxt[i] = ST_WB;
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            count <= '0;
            for (int i = 0; i < NUM_SLOTS; i++) begin
                slot_state[i] <= ST_EMPTY;
            end
        end else begin
            count <= count + COUNT_W'(accept) - COUNT_W'(retire);
            // slots above the retiring one move down by one
            for (int i = 0; i < NUM_SLOTS - 1; i++) begin
                if (retire && SLOT_W'(i) >= wb_index) begin
                    slot_state[i] <= state_nxt[i + 1];
                end else begin
                    slot_state[i] <= state_nxt[i];
                end
            end
            slot_state[NUM_SLOTS-1] <= retire ? ST_EMPTY : state_nxt[NUM_SLOTS-1];
            if (accept) begin
                slot_state[app_index] <= ST_ISSUED;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_SLOTS - 1; i++) begin
            if (retire && SLOT_W'(i) >= wb_index) begin
                unit_q[i]  <= unit_q[i + 1];
                entry_q[i] <= entry_q[i + 1];
            end
        end
        if (accept) begin
            unit_q[app_index]  <= instr_unit;
            entry_q[app_index] <= {instr_dest, instr_op, instr_vsew, instr_lmul, instr_sel_a,
                                   instr_sel_b, instr_src_a, instr_src_b, instr_imm};
        end
    end

    // occupancy stays within the table and matches the filled slots
    assert property (@(posedge clk) disable iff (!nrst)
        count <= COUNT_W'(NUM_SLOTS) &&
        (count == '0 || slot_state[SLOT_W'(count - COUNT_W'(1))] != ST_EMPTY) &&
        (count == COUNT_W'(NUM_SLOTS) || slot_state[SLOT_W'(count)] == ST_EMPTY));

    // each unit works on one entry at a time
    assert property (@(posedge clk) disable iff (!nrst)
        $onehot0(exec_alu) && $onehot0(exec_mul));

endmodule

// ==== src/operand_check.sv ====
// ---------------------------------------------------------------------
// read-after-write hazard check
// compares the read-stage source registers against the
// destinations of older entries still in the table
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module operand_check (
    input  logic                       read_valid,
    input  logic [seq_pkg::SLOT_W-1:0] read_index,
    input  logic [seq_pkg::SEL_W-1:0]  read_sel_a,
    input  logic [seq_pkg::SEL_W-1:0]  read_sel_b,
    input  logic [seq_pkg::REG_W-1:0]  read_src_a,
    input  logic [seq_pkg::REG_W-1:0]  read_src_b,
    input  seq_pkg::entry_state_e      slot_state [seq_pkg::NUM_SLOTS],
    input  logic [seq_pkg::REG_W-1:0]  slot_dest [seq_pkg::NUM_SLOTS],
    output logic                       operands_ready
);
    import seq_pkg::*;

    logic match_a;
    logic match_b;
    logic vreg_a;
    logic vreg_b;

    // scalar and immediate operands never wait on a register
    assign vreg_a = (read_sel_a == SEL_VREG) || (read_sel_a == SEL_VREG_ALT);
    assign vreg_b = (read_sel_b == SEL_VREG) || (read_sel_b == SEL_VREG_ALT);

    always_comb begin
        match_a = 1'b0;
        match_b = 1'b0;
        // only slots below the read entry are older
        for (int i = 0; i < NUM_SLOTS; i++) begin
            if (SLOT_W'(i) < read_index && slot_state[i] != ST_EMPTY) begin
                if (slot_dest[i] == read_src_a) begin
                    match_a = 1'b1;
                end
                if (slot_dest[i] == read_src_b) begin
                    match_b = 1'b1;
                end
            end
        end
    end

    assign operands_ready = read_valid && !(vreg_a && match_a) && !(vreg_b && match_b);

endmodule

// ==== src/fu_slot.sv ====
// ---------------------------------------------------------------------
// functional unit slot
// dispatch register, held request toward the unit, busy flag
// and result capture on the done pulse
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module fu_slot #(
    parameter seq_pkg::fu_e UNIT = seq_pkg::FU_ALU
) (
    input  logic                        clk,
    input  logic                        nrst,
    input  logic                        read_valid,
    input  seq_pkg::fu_e                read_unit,
    input  logic                        operands_ready,
    input  logic [seq_pkg::OP_W-1:0]    read_op,
    input  logic [seq_pkg::VTYPE_W-1:0] read_vsew,
    input  logic [seq_pkg::VTYPE_W-1:0] read_lmul,
    input  logic [seq_pkg::SEL_W-1:0]   read_sel_a,
    input  logic [seq_pkg::SEL_W-1:0]   read_sel_b,
    input  logic [seq_pkg::REG_W-1:0]   read_src_a,
    input  logic [seq_pkg::REG_W-1:0]   read_src_b,
    input  logic [seq_pkg::REG_W-1:0]   read_imm,
    input  logic                        done,
    input  logic [seq_pkg::DATA_W-1:0]  result,
    input  logic                        fu_release,
    output logic                        fire,
    output logic                        busy,
    output logic                        unit_valid,
    output logic [seq_pkg::OP_W-1:0]    unit_op,
    output logic [seq_pkg::VTYPE_W-1:0] unit_vsew,
    output logic [seq_pkg::VTYPE_W-1:0] unit_lmul,
    output logic [seq_pkg::SEL_W-1:0]   unit_sel_a,
    output logic [seq_pkg::SEL_W-1:0]   unit_sel_b,
    output logic [seq_pkg::REG_W-1:0]   unit_src_a,
    output logic [seq_pkg::REG_W-1:0]   unit_src_b,
    output logic [seq_pkg::REG_W-1:0]   unit_imm,
    output logic [seq_pkg::DATA_W-1:0]  held_result
);

    // busy covers execution and the wait for write-back
    assign fire = read_valid && (read_unit == UNIT) && operands_ready && !busy;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            busy       <= 1'b0;
            unit_valid <= 1'b0;
        end else if (fire) begin
            busy       <= 1'b1;
            unit_valid <= 1'b1;
        end else begin
            if (done) begin
                unit_valid <= 1'b0;
            end
            if (fu_release) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            unit_op    <= read_op;
            unit_vsew  <= read_vsew;
            unit_lmul  <= read_lmul;
            unit_sel_a <= read_sel_a;
            unit_sel_b <= read_sel_b;
            unit_src_a <= read_src_a;
            unit_src_b <= read_src_b;
            unit_imm   <= read_imm;
        end
        if (unit_valid && done) begin
            held_result <= result;
        end
    end

    // the unit answers only a pending request
    assert property (@(posedge clk) disable iff (!nrst) done |-> unit_valid);

endmodule

// ==== src/writeback_ctrl.sv ====
// ---------------------------------------------------------------------
// write-back control
// writes the oldest finished entry to the vector register file,
// retires it from the table and frees its unit
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module writeback_ctrl (
    input  logic                       clk,
    input  logic                       nrst,
    input  logic                       wb_valid,
    input  seq_pkg::fu_e               wb_unit,
    input  logic [seq_pkg::REG_W-1:0]  wb_dest,
    input  logic [seq_pkg::DATA_W-1:0] alu_result,
    input  logic [seq_pkg::DATA_W-1:0] mul_result,
    output logic                       v_reg_wr_en,
    output logic [seq_pkg::REG_W-1:0]  dest_wb,
    output logic [seq_pkg::DATA_W-1:0] reg_wr_data,
    output logic                       retire,
    output logic                       alu_release,
    output logic                       mul_release
);
    import seq_pkg::*;

    // one entry leaves per edge, on the edge its write registers
    assign retire      = wb_valid;
    assign alu_release = wb_valid && (wb_unit == FU_ALU);
    assign mul_release = wb_valid && (wb_unit == FU_MUL);

    always_ff @(posedge clk) begin
        if (!nrst) begin
            v_reg_wr_en <= 1'b0;
        end else begin
            v_reg_wr_en <= wb_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_valid) begin
            dest_wb     <= wb_dest;
            reg_wr_data <= (wb_unit == FU_MUL) ? mul_result : alu_result;
        end
    end

endmodule

// ==== src/v_sequencer.sv ====
// ---------------------------------------------------------------------
// vector coprocessor sequencer, top level
// status table, hazard check, alu and multiplier slots,
// register file write-back
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module v_sequencer (
    input  logic                        clk,
    input  logic                        nrst,
    input  logic                        instr_valid,
    output logic                        instr_ready,
    input  seq_pkg::fu_e                instr_unit,
    input  logic [seq_pkg::OP_W-1:0]    instr_op,
    input  logic [seq_pkg::VTYPE_W-1:0] instr_vsew,
    input  logic [seq_pkg::VTYPE_W-1:0] instr_lmul,
    input  logic [seq_pkg::SEL_W-1:0]   instr_sel_a,
    input  logic [seq_pkg::SEL_W-1:0]   instr_sel_b,
    input  logic [seq_pkg::REG_W-1:0]   instr_src_a,
    input  logic [seq_pkg::REG_W-1:0]   instr_src_b,
    input  logic [seq_pkg::REG_W-1:0]   instr_dest,
    input  logic [seq_pkg::REG_W-1:0]   instr_imm,
    output logic                        alu_valid,
    output logic [seq_pkg::OP_W-1:0]    alu_op,
    output logic [seq_pkg::VTYPE_W-1:0] alu_vsew,
    output logic [seq_pkg::VTYPE_W-1:0] alu_lmul,
    output logic [seq_pkg::SEL_W-1:0]   alu_sel_a,
    output logic [seq_pkg::SEL_W-1:0]   alu_sel_b,
    output logic [seq_pkg::REG_W-1:0]   alu_src_a,
    output logic [seq_pkg::REG_W-1:0]   alu_src_b,
    output logic [seq_pkg::REG_W-1:0]   alu_imm,
    input  logic                        done_alu,
    input  logic [seq_pkg::DATA_W-1:0]  result_alu,
    output logic                        mul_valid,
    output logic [seq_pkg::OP_W-1:0]    mul_op,
    output logic [seq_pkg::VTYPE_W-1:0] mul_vsew,
    output logic [seq_pkg::VTYPE_W-1:0] mul_lmul,
    output logic [seq_pkg::SEL_W-1:0]   mul_sel_a,
    output logic [seq_pkg::SEL_W-1:0]   mul_sel_b,
    output logic [seq_pkg::REG_W-1:0]   mul_src_a,
    output logic [seq_pkg::REG_W-1:0]   mul_src_b,
    output logic [seq_pkg::REG_W-1:0]   mul_imm,
    input  logic                        done_mul,
    input  logic [seq_pkg::DATA_W-1:0]  result_mul,
    output logic                        v_reg_wr_en,
    output logic [seq_pkg::REG_W-1:0]   dest_wb,
    output logic [seq_pkg::DATA_W-1:0]  reg_wr_data
);
    import seq_pkg::*;

    // read-stage entry
    logic               read_valid;
    fu_e                read_unit;
    logic [SLOT_W-1:0]  read_index;
    logic [OP_W-1:0]    read_op;
    logic [VTYPE_W-1:0] read_vsew;
    logic [VTYPE_W-1:0] read_lmul;
    logic [SEL_W-1:0]   read_sel_a;
    logic [SEL_W-1:0]   read_sel_b;
    logic [REG_W-1:0]   read_src_a;
    logic [REG_W-1:0]   read_src_b;
    logic [REG_W-1:0]   read_imm;
    entry_state_e       slot_state [NUM_SLOTS];
    logic [REG_W-1:0]   slot_dest [NUM_SLOTS];
    logic               operands_ready;

    // dispatch and write-back handshakes
    logic               alu_fire;
    logic               mul_fire;
    logic               wb_valid;
    fu_e                wb_unit;
    logic [REG_W-1:0]   wb_dest;
    logic               retire;
    logic               alu_release;
    logic               mul_release;
    // results held by the slots until write-back
    logic [DATA_W-1:0]  alu_result;
    logic [DATA_W-1:0]  mul_result;

    instr_status_table u_table (.*);

    operand_check u_check (.*);

    fu_slot #(.UNIT(FU_ALU)) u_alu_slot (
        .*,
        .done        (done_alu),
        .result      (result_alu),
        .fu_release  (alu_release),
        .fire        (alu_fire),
        .busy        (),
        .unit_valid  (alu_valid),
        .unit_op     (alu_op),
        .unit_vsew   (alu_vsew),
        .unit_lmul   (alu_lmul),
        .unit_sel_a  (alu_sel_a),
        .unit_sel_b  (alu_sel_b),
        .unit_src_a  (alu_src_a),
        .unit_src_b  (alu_src_b),
        .unit_imm    (alu_imm),
        .held_result (alu_result)
    );

    fu_slot #(.UNIT(FU_MUL)) u_mul_slot (
        .*,
        .done        (done_mul),
        .result      (result_mul),
        .fu_release  (mul_release),
        .fire        (mul_fire),
        .busy        (),
        .unit_valid  (mul_valid),
        .unit_op     (mul_op),
        .unit_vsew   (mul_vsew),
        .unit_lmul   (mul_lmul),
        .unit_sel_a  (mul_sel_a),
        .unit_sel_b  (mul_sel_b),
        .unit_src_a  (mul_src_a),
        .unit_src_b  (mul_src_b),
        .unit_imm    (mul_imm),
        .held_result (mul_result)
    );

    writeback_ctrl u_wb (.*);

endmodule

// ==== sim/tb_clock.sv ====
// ----------------------------------------------------------------------
// testbench clock and reset generator
// free running clock, active low reset held for a number of cycles
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic nrst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // release just after an edge, away from the sampling point
    initial begin
        nrst = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        nrst = 1'b1;
    end

endmodule

// ==== sim/tb_v_sequencer.sv ====
// ----------------------------------------------------------------------
// testbench for the vector sequencer
// lfsr driven instruction stream, alu and multiplier models,
// scoreboard for ready, dispatch order, hazards and write-back
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module tb_v_sequencer;
    import seq_pkg::*;

    localparam int NUM_INSTR = 200;
    // issue, read, dispatch, up to six done cycles, write-back, release
    localparam int MAX_LAT   = 12;
    localparam int LIMIT     = NUM_INSTR * MAX_LAT;
    localparam int NUM_TESTS = 6;
    localparam int T_RESET   = 0;
    localparam int T_READY   = 1;
    localparam int T_DISP    = 2;
    localparam int T_HAZ     = 3;
    localparam int T_WB      = 4;
    localparam int T_PAR     = 5;

    logic               clk;
    logic               nrst;
    logic               instr_valid;
    logic               instr_ready;
    fu_e                instr_unit;
    logic [OP_W-1:0]    instr_op;
    logic [VTYPE_W-1:0] instr_vsew;
    logic [VTYPE_W-1:0] instr_lmul;
    logic [SEL_W-1:0]   instr_sel_a;
    logic [SEL_W-1:0]   instr_sel_b;
    logic [REG_W-1:0]   instr_src_a;
    logic [REG_W-1:0]   instr_src_b;
    logic [REG_W-1:0]   instr_dest;
    logic [REG_W-1:0]   instr_imm;
    logic               alu_valid;
    logic [OP_W-1:0]    alu_op;
    logic [VTYPE_W-1:0] alu_vsew;
    logic [VTYPE_W-1:0] alu_lmul;
    logic [SEL_W-1:0]   alu_sel_a;
    logic [SEL_W-1:0]   alu_sel_b;
    logic [REG_W-1:0]   alu_src_a;
    logic [REG_W-1:0]   alu_src_b;
    logic [REG_W-1:0]   alu_imm;
    logic               done_alu;
    logic [DATA_W-1:0]  result_alu;
    logic               mul_valid;
    logic [OP_W-1:0]    mul_op;
    logic [VTYPE_W-1:0] mul_vsew;
    logic [VTYPE_W-1:0] mul_lmul;
    logic [SEL_W-1:0]   mul_sel_a;
    logic [SEL_W-1:0]   mul_sel_b;
    logic [REG_W-1:0]   mul_src_a;
    logic [REG_W-1:0]   mul_src_b;
    logic [REG_W-1:0]   mul_imm;
    logic               done_mul;
    logic [DATA_W-1:0]  result_mul;
    logic               v_reg_wr_en;
    logic [REG_W-1:0]   dest_wb;
    logic [DATA_W-1:0]  reg_wr_data;

    // instruction stream and scoreboard state
    fu_e              i_unit [NUM_INSTR];
    logic [26:0]      i_fld [NUM_INSTR];
    logic [REG_W-1:0] i_dest [NUM_INSTR];
    bit               finished [NUM_INSTR];
    bit               written [NUM_INSTR];
    logic [15:0]      lfsr;
    int               errs [NUM_TESTS];
    string            names [NUM_TESTS] = '{"reset", "ready", "dispatch", "hazard",
                                            "writeback", "parallel"};
    int               n_issued;
    int               n_written;
    int               next_disp;
    int               cycles;
    int               alu_id;
    int               mul_id;
    int               alu_wait;
    int               mul_wait;
    int               bypass_seen;
    int               both_seen;
    int               full_seen;
    logic             prev_alu_valid;
    logic             prev_mul_valid;
    logic             offered;

    tb_clock u_clock (.*);

    v_sequencer UUT (.*);

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] draw(input int nbits);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = lfsr_step(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // unit answer built from op, sources and immediate
    function automatic logic [DATA_W-1:0] unit_result(input fu_e unit, input logic [26:0] f);
        logic [31:0] w;
        w = {f[26:23], f[14:10], f[9:5], f[4:0], 11'h2a5, unit};
        return {w, ~w, w ^ 32'h5a5a_5a5a, w + 32'd1};
    endfunction

    task automatic compare(input int test, input logic [DATA_W-1:0] expected,
                           input logic [DATA_W-1:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s: expected %0h, actual %0h", names[test], expected, actual);
            errs[test]++;
        end
    endtask

    task automatic hazard_probe(input logic [REG_W-1:0] dest, input logic [SEL_W-1:0] sel,
                                input logic [REG_W-1:0] src);
        if (dest == src) begin
            if (sel == SEL_VREG || sel == SEL_VREG_ALT) begin
                $display("ERROR hazard: instruction %0d dispatched while v%0d is still pending",
                         next_disp, src);
                errs[T_HAZ]++;
            end else begin
                bypass_seen++;
            end
        end
    endtask

    task automatic check_dispatch(input fu_e unit, input logic [26:0] fields, output int id);
        logic [26:0] f;
        id = next_disp;
        if (next_disp >= n_issued) begin
            $display("ERROR dispatch: %s started with no instruction waiting", unit.name());
            errs[T_DISP]++;
            id = 0;
        end else begin
            f = i_fld[next_disp];
            compare(T_DISP, DATA_W'(i_unit[next_disp]), DATA_W'(unit));
            compare(T_DISP, DATA_W'(f), DATA_W'(fields));
            // older unwritten entries still block vector register reads
            for (int i = 0; i < next_disp; i++) begin
                if (!written[i]) begin
                    hazard_probe(i_dest[i], f[18:17], f[14:10]);
                    hazard_probe(i_dest[i], f[16:15], f[9:5]);
                end
            end
            next_disp++;
        end
    endtask

    // oldest finished entry must be written on this edge
    task automatic check_write();
        int oldest;
        oldest = -1;
        for (int i = NUM_INSTR - 1; i >= 0; i--) begin
            if (finished[i] && !written[i]) begin
                oldest = i;
            end
        end
        compare(T_WB, DATA_W'(oldest >= 0), DATA_W'(v_reg_wr_en));
        if (v_reg_wr_en && oldest >= 0) begin
            compare(T_WB, DATA_W'(i_dest[oldest]), DATA_W'(dest_wb));
            compare(T_WB, unit_result(i_unit[oldest], i_fld[oldest]), reg_wr_data);
            written[oldest] = 1'b1;
            n_written++;
        end
    endtask

    // unit model: random latency, one done pulse per request
    task automatic model_unit(input fu_e unit, input logic valid, input logic prev_valid,
                              input logic [26:0] fields, input int id, inout int wait_cnt,
                              inout logic done, inout logic [DATA_W-1:0] result);
        if (done) begin
            compare(T_DISP, '0, DATA_W'(valid));
            finished[id] = 1'b1;
            done = 1'b0;
        end
        if (valid && !prev_valid) begin
            wait_cnt = 1 + int'(draw(3)) % 6;
        end
        if (wait_cnt > 0) begin
            wait_cnt--;
            if (wait_cnt == 0) begin
                done = 1'b1;
                result = unit_result(unit, fields);
            end
        end
    endtask

    // offer the next instruction, held until accepted
    task automatic drive_issue();
        logic go;
        go = (draw(2) != 0);
        if (offered || !instr_valid) begin
            instr_valid = (n_issued < NUM_INSTR) && go;
        end
        if (n_issued < NUM_INSTR) begin
            instr_unit = i_unit[n_issued];
            {instr_op, instr_vsew, instr_lmul, instr_sel_a, instr_sel_b,
             instr_src_a, instr_src_b, instr_imm} = i_fld[n_issued];
            instr_dest = i_dest[n_issued];
        end
        offered = instr_valid && instr_ready;
    endtask

    initial begin
        logic [31:0] r;
        int failed;
        lfsr = 16'd39696;
        instr_valid = 1'b0;
        instr_unit = FU_NONE;
        {instr_op, instr_vsew, instr_lmul, instr_sel_a, instr_sel_b,
         instr_src_a, instr_src_b, instr_imm} = '0;
        instr_dest = '0;
        done_alu = 1'b0;
        done_mul = 1'b0;
        result_alu = '0;
        result_mul = '0;
        n_issued = 0;
        n_written = 0;
        next_disp = 0;
        cycles = 0;
        alu_id = 0;
        mul_id = 0;
        alu_wait = 0;
        mul_wait = 0;
        bypass_seen = 0;
        both_seen = 0;
        full_seen = 0;
        offered = 1'b0;
        failed = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            errs[t] = 0;
        end
        // registers limited to v0..v3 so hazards come often
        for (int k = 0; k < NUM_INSTR; k++) begin
            r = draw(1);
            i_unit[k] = r[0] ? FU_MUL : FU_ALU;
            r = draw(21);
            i_fld[k] = {r[20:9], 3'b000, r[8:7], 3'b000, r[6:5], r[4:0]};
            r = draw(2);
            i_dest[k] = {3'b000, r[1:0]};
            finished[k] = 1'b0;
            written[k] = 1'b0;
        end

        wait (nrst === 1'b1);
        compare(T_RESET, DATA_W'(1'b1), DATA_W'(instr_ready));
        compare(T_RESET, '0, DATA_W'(alu_valid));
        compare(T_RESET, '0, DATA_W'(mul_valid));
        compare(T_RESET, '0, DATA_W'(v_reg_wr_en));
        $display("test %-10s %s", names[T_RESET], errs[T_RESET] == 0 ? "pass" : "FAIL");
        prev_alu_valid = alu_valid;
        prev_mul_valid = mul_valid;

        while (n_written < NUM_INSTR && cycles < LIMIT) begin
            @(posedge clk);
            #1;
            cycles++;
            if (offered) begin
                n_issued++;
            end
            if (alu_valid && !prev_alu_valid) begin
                check_dispatch(FU_ALU, {alu_op, alu_vsew, alu_lmul, alu_sel_a, alu_sel_b,
                                        alu_src_a, alu_src_b, alu_imm}, alu_id);
            end
            if (mul_valid && !prev_mul_valid) begin
                check_dispatch(FU_MUL, {mul_op, mul_vsew, mul_lmul, mul_sel_a, mul_sel_b,
                                        mul_src_a, mul_src_b, mul_imm}, mul_id);
            end
            check_write();
            model_unit(FU_ALU, alu_valid, prev_alu_valid, {alu_op, alu_vsew, alu_lmul,
                       alu_sel_a, alu_sel_b, alu_src_a, alu_src_b, alu_imm}, alu_id,
                       alu_wait, done_alu, result_alu);
            model_unit(FU_MUL, mul_valid, prev_mul_valid, {mul_op, mul_vsew, mul_lmul,
                       mul_sel_a, mul_sel_b, mul_src_a, mul_src_b, mul_imm}, mul_id,
                       mul_wait, done_mul, result_mul);
            compare(T_READY, DATA_W'(n_issued - n_written < NUM_SLOTS), DATA_W'(instr_ready));
            if (alu_valid && mul_valid) begin
                both_seen++;
            end
            if (!instr_ready) begin
                full_seen++;
            end
            prev_alu_valid = alu_valid;
            prev_mul_valid = mul_valid;
            drive_issue();
        end

        if (cycles >= LIMIT) begin
            $display("ERROR timeout: %0d of %0d instructions written after %0d cycles",
                     n_written, NUM_INSTR, cycles);
            errs[T_PAR]++;
        end
        if (bypass_seen == 0) begin
            $display("ERROR hazard: no scalar or immediate operand passed a matching register");
            errs[T_HAZ]++;
        end
        if (both_seen == 0) begin
            $display("ERROR parallel: alu and multiplier never busy together");
            errs[T_PAR]++;
        end
        if (full_seen == 0) begin
            $display("ERROR parallel: the table never filled up");
            errs[T_PAR]++;
        end
        for (int t = T_READY; t < NUM_TESTS; t++) begin
            $display("test %-10s %s", names[t], errs[t] == 0 ? "pass" : "FAIL");
        end
        for (int t = 0; t < NUM_TESTS; t++) begin
            if (errs[t] != 0) begin
                failed++;
            end
        end
        $display("%0d tests run, %0d passed, %0d failed", NUM_TESTS, NUM_TESTS - failed, failed);
        if (failed == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
src/seq_pkg.sv
src/instr_status_table.sv
src/operand_check.sv
src/fu_slot.sv
src/writeback_ctrl.sv
src/v_sequencer.sv
sim/tb_clock.sv
sim/tb_v_sequencer.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the sequencer testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f files.f --top-module tb_v_sequencer \
        -Mdir obj_dir -o tb_v_sequencer \
    && ./obj_dir/tb_v_sequencer > sim.log 2>&1 ; cat sim.log ; \
    grep -qx "all tests passed" sim.log \
    && echo "simulation ok" \
    || { echo "simulation reported failure"; exit 1; }
